/* design/rv_core_pkg.sv */
// RV32I core shared widths, word types, ALU operations, forwarding codes and opcodes
package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation selects
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10; // LUI takes the immediate straight through

    // Operand source picked by the hazard unit
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_NONE      = 2'd0; // Register file read
    localparam fwd_sel_t FWD_EXECUTE   = 2'd1; // ALU output of the instruction in execute
    localparam fwd_sel_t FWD_WRITEBACK = 2'd2; // Value held in the writeback register

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Alternate funct7 pattern marks SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // funct3 values shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* design/register_file.sv */
// Integer register file with two combinational reads, one write port and x0 tied to zero
`timescale 1ns/1ps

module register_file (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o,
    input  logic                  wr_en_i,
    input  rv_core_pkg::reg_addr_t wr_addr_i,
    input  rv_core_pkg::word_t     wr_data_i
);

    rv_core_pkg::word_t regs [1:31]; // No storage behind x0

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // Written value reads back next cycle, while a write aimed at x0 still reads zero
    assert property (@(posedge clk_i) disable iff (reset_i)
        wr_en_i |=>
            ((rs1_addr_i != $past(wr_addr_i)) ||
             (rs1_data_o == (($past(wr_addr_i) == '0) ? '0 : $past(wr_data_i)))))
        else $error("Register read back differs from the value written to it");

endmodule

/* design/hazard_unit.sv */
// Hazard unit picking each operand's forwarding source from the in-flight destinations
`timescale 1ns/1ps

module hazard_unit (
    input  rv_core_pkg::reg_addr_t rs1_i,
    input  rv_core_pkg::reg_addr_t rs2_i,
    input  logic                   ex_valid_i,
    input  logic                   ex_illegal_i,
    input  rv_core_pkg::reg_addr_t ex_rd_i,
    input  logic                   wb_valid_i,
    input  logic                   wb_illegal_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    output rv_core_pkg::fwd_sel_t  fwd_a_sel_o,
    output rv_core_pkg::fwd_sel_t  fwd_b_sel_o
);

    logic ex_live; // Execute will write a real register
    logic wb_live;

    assign ex_live = ex_valid_i && !ex_illegal_i && (ex_rd_i != '0);
    assign wb_live = wb_valid_i && !wb_illegal_i && (wb_rd_i != '0);

    // Younger result in execute shadows the one in writeback
    assign fwd_a_sel_o = (ex_live && rs1_i == ex_rd_i) ? rv_core_pkg::FWD_EXECUTE   :
                         (wb_live && rs1_i == wb_rd_i) ? rv_core_pkg::FWD_WRITEBACK :
                                                         rv_core_pkg::FWD_NONE;

    assign fwd_b_sel_o = (ex_live && rs2_i == ex_rd_i) ? rv_core_pkg::FWD_EXECUTE   :
                         (wb_live && rs2_i == wb_rd_i) ? rv_core_pkg::FWD_WRITEBACK :
                                                         rv_core_pkg::FWD_NONE;

    // Decode treats the spare code as a register read, so it must never appear
    always_comb begin
        assert final (fwd_a_sel_o inside {rv_core_pkg::FWD_NONE, rv_core_pkg::FWD_EXECUTE,
                                          rv_core_pkg::FWD_WRITEBACK})
            else $error("Operand a select took the unused code");
        assert final (fwd_b_sel_o inside {rv_core_pkg::FWD_NONE, rv_core_pkg::FWD_EXECUTE,
                                          rv_core_pkg::FWD_WRITEBACK})
            else $error("Operand b select took the unused code");
    end

endmodule

/* design/decode_stage.sv */
// Decode stage with instruction decode, immediates, operand forwarding and the decode register
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   hold_i,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,

    output rv_core_pkg::reg_addr_t rs1_addr_o,
    output rv_core_pkg::reg_addr_t rs2_addr_o,
    input  rv_core_pkg::word_t     rs1_data_i,
    input  rv_core_pkg::word_t     rs2_data_i,

    input  rv_core_pkg::fwd_sel_t  fwd_a_sel_i,
    input  rv_core_pkg::fwd_sel_t  fwd_b_sel_i,
    input  rv_core_pkg::word_t     exe_result_i,
    input  rv_core_pkg::word_t     wb_value_i,

    output logic                   dec_valid_o,
    output logic                   dec_illegal_o,
    output rv_core_pkg::alu_op_t   dec_alu_op_o,
    output rv_core_pkg::word_t     dec_operand_a_o,
    output rv_core_pkg::word_t     dec_operand_b_o,
    output rv_core_pkg::reg_addr_t dec_rd_o
);

    // Operation implied by funct3 alone
    function automatic rv_core_pkg::alu_op_t f3_to_alu_op(input logic [2:0] f3);
        case (f3)
            rv_core_pkg::F3_SLL:  return rv_core_pkg::ALU_SLL;
            rv_core_pkg::F3_SLT:  return rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_SLTU: return rv_core_pkg::ALU_SLTU;
            rv_core_pkg::F3_XOR:  return rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_SRL:  return rv_core_pkg::ALU_SRL;
            rv_core_pkg::F3_OR:   return rv_core_pkg::ALU_OR;
            rv_core_pkg::F3_AND:  return rv_core_pkg::ALU_AND;
            default:              return rv_core_pkg::ALU_ADD;
        endcase
    endfunction

    function automatic rv_core_pkg::word_t fwd_mux(input rv_core_pkg::fwd_sel_t sel,
                                                   input rv_core_pkg::word_t rf_val,
                                                   input rv_core_pkg::word_t exe_val,
                                                   input rv_core_pkg::word_t wb_val);
        case (sel)
            rv_core_pkg::FWD_EXECUTE:   return exe_val;
            rv_core_pkg::FWD_WRITEBACK: return wb_val;
            default:                    return rf_val;
        endcase
    endfunction

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    rv_core_pkg::word_t   i_imm;
    rv_core_pkg::word_t   shamt_imm;
    rv_core_pkg::word_t   u_imm;
    rv_core_pkg::word_t   imm;
    rv_core_pkg::alu_op_t alu_op_d;
    logic                 illegal_d;
    logic                 use_imm;

    rv_core_pkg::word_t operand_a_d;
    rv_core_pkg::word_t operand_b_fwd;
    rv_core_pkg::word_t operand_b_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign i_imm     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign shamt_imm = {27'b0, instr_i[24:20]}; // Immediate shifts only
    assign u_imm     = {instr_i[31:12], 12'b0};

    always_comb begin
        alu_op_d  = f3_to_alu_op(funct3);
        illegal_d = 1'b0;
        use_imm   = 1'b0;
        imm       = i_imm;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                if (funct7 == rv_core_pkg::FUNCT7_ALT && funct3 == rv_core_pkg::F3_ADD) begin
                    alu_op_d = rv_core_pkg::ALU_SUB;
                end else if (funct7 == rv_core_pkg::FUNCT7_ALT &&
                             funct3 == rv_core_pkg::F3_SRL) begin
                    alu_op_d = rv_core_pkg::ALU_SRA;
                end else if (funct7 != rv_core_pkg::FUNCT7_BASE) begin
                    illegal_d = 1'b1;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // Shift forms keep funct7 in the upper immediate bits
                if (funct3 == rv_core_pkg::F3_SLL || funct3 == rv_core_pkg::F3_SRL) begin
                    imm = shamt_imm;
                    if (funct3 == rv_core_pkg::F3_SRL && funct7 == rv_core_pkg::FUNCT7_ALT) begin
                        alu_op_d = rv_core_pkg::ALU_SRA;
                    end else if (funct7 != rv_core_pkg::FUNCT7_BASE) begin
                        illegal_d = 1'b1;
                    end
                end
            end
            rv_core_pkg::OPC_LUI: begin
                alu_op_d = rv_core_pkg::ALU_PASS_B;
                use_imm  = 1'b1;
                imm      = u_imm;
            end
            default: begin
                alu_op_d  = rv_core_pkg::ALU_ADD;
                illegal_d = 1'b1;
            end
        endcase
    end

    assign operand_a_d   = fwd_mux(fwd_a_sel_i, rs1_data_i, exe_result_i, wb_value_i);
    assign operand_b_fwd = fwd_mux(fwd_b_sel_i, rs2_data_i, exe_result_i, wb_value_i);
    assign operand_b_d   = use_imm ? imm : operand_b_fwd; // Immediate wins after forwarding

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_valid_o     <= 1'b0;
            dec_illegal_o   <= 1'b0;
            dec_alu_op_o    <= rv_core_pkg::ALU_ADD;
            dec_operand_a_o <= '0;
            dec_operand_b_o <= '0;
            dec_rd_o        <= '0;
        end else if (!hold_i) begin
            dec_valid_o     <= instr_valid_i;
            dec_illegal_o   <= illegal_d;
            dec_alu_op_o    <= alu_op_d;
            dec_operand_a_o <= operand_a_d;
            dec_operand_b_o <= operand_b_d;
            dec_rd_o        <= instr_i[11:7];
        end
    end

    // A bad encoding in execute has no result that a younger instruction may use
    assert property (@(posedge clk_i) disable iff (reset_i)
        (dec_valid_o && dec_illegal_o) |->
            (fwd_a_sel_i != rv_core_pkg::FWD_EXECUTE &&
             fwd_b_sel_i != rv_core_pkg::FWD_EXECUTE))
        else $error("Illegal instruction in execute was forwarded as a legal result");

endmodule

/* design/execute_stage.sv */
// Execute stage with the ALU and the writeback register feeding the result ports
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   hold_i,
    input  logic                   dec_valid_i,
    input  logic                   dec_illegal_i,
    input  rv_core_pkg::alu_op_t   dec_alu_op_i,
    input  rv_core_pkg::word_t     dec_operand_a_i,
    input  rv_core_pkg::word_t     dec_operand_b_i,
    input  rv_core_pkg::reg_addr_t dec_rd_i,
    output rv_core_pkg::word_t     exe_result_o,
    output logic                   wb_valid_o,
    output logic                   wb_illegal_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_value_o
);

    rv_core_pkg::word_t alu_result;
    logic [4:0]         shamt;

    assign shamt = dec_operand_b_i[4:0]; // RV32 shift amount

    always_comb begin
        case (dec_alu_op_i)
            rv_core_pkg::ALU_ADD:    alu_result = dec_operand_a_i + dec_operand_b_i;
            rv_core_pkg::ALU_SUB:    alu_result = dec_operand_a_i - dec_operand_b_i;
            rv_core_pkg::ALU_AND:    alu_result = dec_operand_a_i & dec_operand_b_i;
            rv_core_pkg::ALU_OR:     alu_result = dec_operand_a_i | dec_operand_b_i;
            rv_core_pkg::ALU_XOR:    alu_result = dec_operand_a_i ^ dec_operand_b_i;
            rv_core_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(dec_operand_a_i) < $signed(dec_operand_b_i)};
            end
            rv_core_pkg::ALU_SLTU: begin
                alu_result = {31'b0, dec_operand_a_i < dec_operand_b_i};
            end
            rv_core_pkg::ALU_SLL:    alu_result = dec_operand_a_i << shamt;
            rv_core_pkg::ALU_SRL:    alu_result = dec_operand_a_i >> shamt;
            rv_core_pkg::ALU_SRA:    alu_result = $signed(dec_operand_a_i) >>> shamt;
            rv_core_pkg::ALU_PASS_B: alu_result = dec_operand_b_i;
            default:                 alu_result = '0;
        endcase
    end

    // Forwarded to decode in the same cycle
    assign exe_result_o = alu_result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_o   <= 1'b0;
            wb_illegal_o <= 1'b0;
            wb_rd_o      <= '0;
            wb_value_o   <= '0;
        end else if (!hold_i) begin
            wb_valid_o   <= dec_valid_i;
            wb_illegal_o <= dec_illegal_i;
            wb_rd_o      <= dec_rd_i;
            wb_value_o   <= dec_illegal_i ? '0 : alu_result; // Bad encodings report zero
        end
    end

    // Decode freezes together with execute, or the instruction in execute would move on
    assert property (@(posedge clk_i) disable iff (reset_i)
        hold_i |=> ($stable(dec_valid_i) && $stable(dec_illegal_i) &&
                    $stable(dec_alu_op_i) && $stable(dec_rd_i) &&
                    $stable(dec_operand_a_i) && $stable(dec_operand_b_i)))
        else $error("Decode register changed while held");

endmodule

/* design/core_pipeline_top.sv */
// Core pipeline top joining decode, hazard detection, execute and the register file
`timescale 1ns/1ps

module core_pipeline_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   hold_i,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,
    output logic                   wb_valid_o,
    output logic                   wb_illegal_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_value_o
);

    rv_core_pkg::reg_addr_t rs1_addr;
    rv_core_pkg::reg_addr_t rs2_addr;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::fwd_sel_t  fwd_a_sel;
    rv_core_pkg::fwd_sel_t  fwd_b_sel;
    rv_core_pkg::word_t     exe_result;

    logic                   dec_valid;
    logic                   dec_illegal;
    rv_core_pkg::alu_op_t   dec_alu_op;
    rv_core_pkg::word_t     dec_operand_a;
    rv_core_pkg::word_t     dec_operand_b;
    rv_core_pkg::reg_addr_t dec_rd;

    logic rf_wr_en;

    // Only legal results retire, and nothing retires while frozen
    assign rf_wr_en = wb_valid_o && !wb_illegal_o && !hold_i;

    decode_stage u_decode (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .hold_i          (hold_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .fwd_a_sel_i     (fwd_a_sel),
        .fwd_b_sel_i     (fwd_b_sel),
        .exe_result_i    (exe_result),
        .wb_value_i      (wb_value_o),
        .dec_valid_o     (dec_valid),
        .dec_illegal_o   (dec_illegal),
        .dec_alu_op_o    (dec_alu_op),
        .dec_operand_a_o (dec_operand_a),
        .dec_operand_b_o (dec_operand_b),
        .dec_rd_o        (dec_rd)
    );

    hazard_unit u_hazard (
        .rs1_i        (rs1_addr),
        .rs2_i        (rs2_addr),
        .ex_valid_i   (dec_valid),   // Decode register holds the instruction in execute
        .ex_illegal_i (dec_illegal),
        .ex_rd_i      (dec_rd),
        .wb_valid_i   (wb_valid_o),
        .wb_illegal_i (wb_illegal_o),
        .wb_rd_i      (wb_rd_o),
        .fwd_a_sel_o  (fwd_a_sel),
        .fwd_b_sel_o  (fwd_b_sel)
    );

    execute_stage u_execute (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .hold_i          (hold_i),
        .dec_valid_i     (dec_valid),
        .dec_illegal_i   (dec_illegal),
        .dec_alu_op_i    (dec_alu_op),
        .dec_operand_a_i (dec_operand_a),
        .dec_operand_b_i (dec_operand_b),
        .dec_rd_i        (dec_rd),
        .exe_result_o    (exe_result),
        .wb_valid_o      (wb_valid_o),
        .wb_illegal_o    (wb_illegal_o),
        .wb_rd_o         (wb_rd_o),
        .wb_value_o      (wb_value_o)
    );

    register_file u_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (rf_wr_en),
        .wr_addr_i  (wb_rd_o),
        .wr_data_i  (wb_value_o)
    );

endmodule

/* test/tb_core_pipeline.sv */
// Random-instruction testbench for the core pipeline with an architectural register model
`timescale 1ns/1ps

module tb_core_pipeline;

    logic                   clk_i = 1'b0;
    logic                   reset_i;
    logic                   hold_i;
    logic                   instr_valid_i;
    rv_core_pkg::word_t     instr_i;
    logic                   wb_valid_o;
    logic                   wb_illegal_o;
    rv_core_pkg::reg_addr_t wb_rd_o;
    rv_core_pkg::word_t     wb_value_o;

    rv_core_pkg::word_t     model_regs [32];
    rv_core_pkg::reg_addr_t exp_rd_q [$];
    rv_core_pkg::word_t     exp_value_q [$];
    bit                     exp_illegal_q [$];
    string                  name_q [$];

    int value_errors = 0;
    int other_errors = 0;
    int accepted = 0;
    int results = 0;

    core_pipeline_top UUT (.*);

    always #10 clk_i = ~clk_i;

    // Ops 0 to 9 are ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
    function automatic logic [2:0] funct3_of(int op);
        case (op)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            6:       return 3'b011;
            7:       return 3'b001;
            8, 9:    return 3'b101;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [6:0] funct7_of(int op);
        return (op == 1 || op == 9) ? 7'b0100000 : 7'b0000000;
    endfunction

    function automatic string op_name(int op, bit is_imm);
        string base;
        case (op)
            0:       base = "add";
            1:       base = "sub";
            2:       base = "and";
            3:       base = "or";
            4:       base = "xor";
            5:       base = "slt";
            6:       base = "sltu";
            7:       base = "sll";
            8:       base = "srl";
            default: base = "sra";
        endcase
        if (!is_imm) return base;
        if (op == 6) return "sltiu";
        return {base, "i"};
    endfunction

    // ISA semantics with shift amounts from the low 5 bits only
    function automatic rv_core_pkg::word_t alu_ref(int op, rv_core_pkg::word_t a,
                                                   rv_core_pkg::word_t b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return (a < b) ? 32'd1 : 32'd0;
            7:       return a << b[4:0];
            8:       return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // Mostly x0..x4 so dependencies come close together
    function automatic rv_core_pkg::reg_addr_t pick_reg();
        if ($urandom_range(3) != 0) return 5'($urandom_range(4));
        return 5'($urandom_range(31));
    endfunction

    task automatic push_expected(rv_core_pkg::reg_addr_t rd, rv_core_pkg::word_t value,
                                 bit illegal, string name);
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(illegal ? 32'd0 : value);
        exp_illegal_q.push_back(illegal);
        name_q.push_back(name);
        if (!illegal && rd != 0) model_regs[rd] = value; // x0 never changes
        accepted++;
    endtask

    task automatic issue_random();
        int r;
        int op;
        rv_core_pkg::reg_addr_t rd, rs1, rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        rv_core_pkg::word_t word, b, value;
        bit illegal, valid, hold;
        string name;
        rd = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        r = $urandom_range(99);
        illegal = 1'b0;
        value = '0;
        if (r < 4) begin
            word = $urandom;
            case ($urandom_range(2))
                0: word[6:0] = 7'b0000011;                            // Load
                1: word[6:0] = 7'b1100011;                            // Branch
                default: word = {7'b0000001, word[24:7], rv_core_pkg::OPC_OP}; // M extension
            endcase
            illegal = 1'b1;
            name = "illegal";
        end else if (r < 12) begin
            imm20 = 20'($urandom);
            word = {imm20, rd, rv_core_pkg::OPC_LUI};
            value = {imm20, 12'h000};
            name = "lui";
        end else if (r < 56) begin
            op = $urandom_range(9);
            word = {funct7_of(op), rs2, rs1, funct3_of(op), rd, rv_core_pkg::OPC_OP};
            value = alu_ref(op, model_regs[rs1], model_regs[rs2]);
            name = op_name(op, 1'b0);
        end else begin
            op = $urandom_range(8); // No SUBI
            if (op != 0) op++;
            if (op >= 7) begin
                imm12 = {funct7_of(op), rs2};
                b = {27'b0, rs2};
            end else begin
                imm12 = 12'($urandom);
                b = {{20{imm12[11]}}, imm12};
            end
            word = {imm12, rs1, funct3_of(op), rd, rv_core_pkg::OPC_OP_IMM};
            value = alu_ref(op, model_regs[rs1], b);
            name = op_name(op, 1'b1);
        end
        valid = $urandom_range(99) < 80;
        hold = $urandom_range(99) < 15;
        instr_i = word;
        instr_valid_i = valid;
        hold_i = hold;
        if (valid && !hold) push_expected(rd, value, illegal, name);
    endtask

    task automatic check_result();
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::word_t value;
        bit illegal;
        string name;
        results++;
        if (exp_rd_q.size() == 0) begin
            other_errors++;
            $display("Error: result at %0t with no instruction outstanding", $time);
            return;
        end
        rd = exp_rd_q.pop_front();
        value = exp_value_q.pop_front();
        illegal = exp_illegal_q.pop_front();
        name = name_q.pop_front();
        if (wb_illegal_o !== illegal) begin
            value_errors++;
            $display("Fail %s illegal: expected %0b, actual %0b", name, illegal, wb_illegal_o);
        end
        if (!illegal && wb_rd_o !== rd) begin
            value_errors++;
            $display("Fail %s rd: expected %0d, actual %0d", name, rd, wb_rd_o);
        end
        if (wb_value_o !== value) begin
            value_errors++;
            $display("Fail %s value: expected %h, actual %h", name, value, wb_value_o);
        end
    endtask

    // A result counts when the next edge is not held
    always @(negedge clk_i) begin
        if (!reset_i && wb_valid_o && !hold_i) check_result();
    end

    // Single instruction into an idle pipeline
    task automatic check_latency();
        int edges;
        bit seen;
        instr_i = {12'h123, 5'd0, 3'b000, 5'd5, rv_core_pkg::OPC_OP_IMM};
        instr_valid_i = 1'b1;
        hold_i = 1'b0;
        push_expected(5'd5, 32'h123, 1'b0, "addi latency");
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < 10) begin
            @(posedge clk_i);
            edges++;
            #2;
            instr_valid_i = 1'b0;
            @(negedge clk_i);
            seen = wb_valid_o;
        end
        if (!seen) begin
            other_errors++;
            $display("Error: no result for the latency instruction within 10 cycles");
        end else if (edges != 2) begin
            value_errors++;
            $display("Fail latency: expected %0d edges, actual %0d edges", 2, edges);
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'hd89a_f558));
        reset_i = 1'b1;
        hold_i = 1'b0;
        instr_valid_i = 1'b1; // Strobe stays high so only the reset can keep wb_valid_o low
        instr_i = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (10) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        instr_valid_i = 1'b0;
        @(negedge clk_i);
        if (wb_valid_o !== 1'b0) begin
            other_errors++;
            $display("Error: wb_valid_o is not low after reset");
        end
        @(posedge clk_i);
        #2;
        check_latency();
        for (int n = 0; n < 2000; n++) begin
            @(posedge clk_i);
            #2;
            issue_random();
        end
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
        hold_i = 1'b0;
        cycles = 0;
        while (exp_rd_q.size() != 0 && cycles < 20) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_rd_q.size() != 0) begin
            other_errors++;
            $display("Error: %0d results never came out", exp_rd_q.size());
        end
        if (results != accepted) begin
            other_errors++;
            $display("Error: %0d results for %0d accepted instructions", results, accepted);
        end
        $display("Value errors %0d, other errors %0d, accepted %0d, results %0d",
                 value_errors, other_errors, accepted, results);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
design/rv_core_pkg.sv
design/register_file.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_pipeline_top.sv
test/tb_core_pipeline.sv

/* Bender.yml */
package:
  name: rv_core_pipeline

sources:
  - design/rv_core_pkg.sv
  - design/register_file.sv
  - design/hazard_unit.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/core_pipeline_top.sv
  - target: test
    files:
      - test/tb_core_pipeline.sv
